// File: request_merge_engine.f
+incdir+hw
hw/request_pkg.sv
hw/request_sync_fifo.sv
hw/request_rr_arbiter.sv
hw/request_merge_engine.sv
sim/request_merge_engine_tb.sv

// File: Makefile
# Verilator flow for the request merge engine
TOP := request_merge_engine_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f request_merge_engine.f \
		--top-module $(TOP) -o $(TOP)

# Exit status of the simulation is the pass or fail result
run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall -f request_merge_engine.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/request_merge_engine_tb.sv
// Single clock, engines send only after ready was high and any error stops the run at once
`include "request_defs.svh"

module request_merge_engine_tb;

  localparam int NUM            = `REQ_NUM_ENGINES;
  localparam int CHK_W          = 80;
  localparam int FAIR_PACKETS   = 8;
  localparam int RANDOM_PACKETS = 2000;
  // Most packets the FIFOs can hold together
  localparam int HOLD_MAX       = `REQ_OUT_DEPTH + NUM * `REQ_IN_DEPTH;
  localparam int TOTAL_PACKETS  = NUM * FAIR_PACKETS + RANDOM_PACKETS + 2 * HOLD_MAX;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_PACKETS + 2000;

  // DUT ports
  logic                         ap_clk;
  logic                         areset_control;
  logic [NUM-1:0]               request_in_valid;
  request_pkg::engine_payload_t request_in_payload [NUM];
  logic [NUM-1:0]               request_ready;
  logic                         request_pop;
  logic                         request_out_valid;
  request_pkg::engine_payload_t request_out_payload;
  logic                         request_out_empty;
  logic                         request_out_prog_full;
  logic                         fifo_setup;

  // Reference model, one queue per engine
  request_pkg::engine_payload_t model_q [NUM][$];
  int                           seq [NUM];
  int                           pushed_total;
  int                           received_total;
  int                           push_limit;
  // Pops that met a non-empty FIFO, one and two cycles back
  logic                         pop_d1;
  logic                         pop_d2;
  // Outputs as seen on the falling edge
  logic [NUM-1:0]               ready_s;
  logic                         empty_s;
  // Round-robin order tracking
  logic                         rr_check;
  int                           rr_next;
  string                        test_name;
  integer                       seed;
  int                           cycle_count = 0;

  request_merge_engine #(
    .NUM_ENGINES(NUM)
  ) uut (
    .ap_clk               (ap_clk),
    .areset_control       (areset_control),
    .request_in_valid     (request_in_valid),
    .request_in_payload   (request_in_payload),
    .request_ready        (request_ready),
    .request_pop          (request_pop),
    .request_out_valid    (request_out_valid),
    .request_out_payload  (request_out_payload),
    .request_out_empty    (request_out_empty),
    .request_out_prog_full(request_out_prog_full),
    .fifo_setup           (fifo_setup)
  );

  // ----------------------------------------------------------------------
  // Clock and cycle limit
  // ----------------------------------------------------------------------
  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run("run went past its cycle limit");
    end
  end

  // ----------------------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("sim failed");
    $display("%s in test %s", msg, test_name);
    $fatal(1);
  endtask

  task automatic compare(input string what, input logic [CHK_W-1:0] expected,
                         input logic [CHK_W-1:0] actual);
    if (expected !== actual) begin
      $display("sim failed");
      $display("Error: test %s, %s: expected %0h, actual %0h",
               test_name, what, expected, actual);
      $fatal(1);
    end
  endtask

  // ----------------------------------------------------------------------
  // Per-cycle stimulus and output checks
  // ----------------------------------------------------------------------
  // Engines still short of n packets
  function automatic logic [NUM-1:0] below_mask(input int n);
    logic [NUM-1:0] m;
    m = '0;
    for (int i = 0; i < NUM; i++) begin
      m[i] = (seq[i] < n);
    end
    return m;
  endfunction

  task automatic observe_outputs(input logic pop_now);
    int                           id;
    request_pkg::engine_payload_t exp_pkt;
    logic                         pop_eff;
    // Pop only counts if the FIFO was not empty in that cycle
    pop_eff = pop_now & ~request_out_empty;
    compare("valid two cycles after pop", CHK_W'(pop_d2), CHK_W'(request_out_valid));
    pop_d2  = pop_d1;
    pop_d1  = pop_eff;
    ready_s = request_ready;
    empty_s = request_out_empty;
    if (request_out_valid) begin
      id = int'(request_out_payload.engine_id);
      if (id >= NUM) begin
        abort_run("output packet carries an engine id outside the engine range");
      end else if (model_q[id].size() == 0) begin
        abort_run("output packet arrived for an engine with nothing outstanding");
      end else begin
        exp_pkt = model_q[id].pop_front();
        compare("output payload", CHK_W'(exp_pkt), CHK_W'(request_out_payload));
        received_total++;
        if (rr_check) begin
          compare("round-robin engine id", CHK_W'(rr_next), CHK_W'(id));
          rr_next = (rr_next + 1) % NUM;
        end
      end
    end
    if (pushed_total - received_total > HOLD_MAX) begin
      abort_run("more packets accepted than the FIFOs can hold");
    end
  endtask

  task automatic run_cycle(input logic [NUM-1:0] push_mask, input logic pop_req);
    logic [NUM-1:0]               fire;
    logic                         pop_now;
    request_pkg::engine_payload_t pkt;
    @(posedge ap_clk);
    fire = '0;
    for (int i = 0; i < NUM; i++) begin
      // Ready from the cycle before gates the send
      if (push_mask[i] && ready_s[i] && pushed_total < push_limit) begin
        pkt.engine_id = `REQ_ENGINE_ID_W'(i);
        pkt.vertex_id = $random(seed);
        pkt.data      = seq[i];
        request_in_payload[i] <= pkt;
        model_q[i].push_back(pkt);
        seq[i]++;
        pushed_total++;
        fire[i] = 1'b1;
      end
    end
    pop_now = pop_req & ~empty_s;
    request_in_valid <= fire;
    request_pop      <= pop_now;
    @(negedge ap_clk);
    observe_outputs(pop_now);
  endtask

  // Pop until every accepted packet came back
  task automatic drain_outputs();
    while (received_total < pushed_total) begin
      run_cycle('0, 1'b1);
    end
    for (int i = 0; i < NUM; i++) begin
      compare("packets left in model queue", '0, CHK_W'(model_q[i].size()));
    end
  endtask

  task automatic check_reset_state();
    compare("request_out_valid in setup", CHK_W'(1'b0), CHK_W'(request_out_valid));
    compare("request_out_empty in setup", CHK_W'(1'b1), CHK_W'(request_out_empty));
    compare("fifo_setup in setup", CHK_W'(1'b1), CHK_W'(fifo_setup));
    compare("request_ready in setup", '0, CHK_W'(request_ready));
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [NUM-1:0] mask;
    logic           saw_prog_full;
    int             waited;
    seed           = 32'he0c2;
    pushed_total   = 0;
    received_total = 0;
    push_limit     = 0;
    pop_d1         = 1'b0;
    pop_d2         = 1'b0;
    ready_s        = '0;
    empty_s        = 1'b1;
    rr_check       = 1'b0;
    rr_next        = 0;
    for (int i = 0; i < NUM; i++) begin
      seq[i] = 0;
      request_in_payload[i] <= '0;
    end
    areset_control   <= 1'b1;
    request_in_valid <= '0;
    request_pop      <= 1'b0;

    // Reset held 10 cycles, FIFO flags settle after the reset copy
    test_name = "reset";
    for (int c = 0; c < 10; c++) begin
      @(posedge ap_clk);
      if (c == 9) begin
        areset_control <= 1'b0;
      end
      @(negedge ap_clk);
      if (c >= 2) begin
        check_reset_state();
      end
    end
    waited = 0;
    while (fifo_setup) begin
      check_reset_state();
      if (waited == `REQ_RST_BUSY_CYCLES + 3) begin
        abort_run("fifo_setup did not fall after reset release");
      end else begin
        run_cycle('0, 1'b0);
        waited++;
      end
    end
    compare("request_ready after setup", CHK_W'({NUM{1'b1}}), CHK_W'(request_ready));

    // All engines load 8 each before any pop
    test_name  = "round-robin";
    push_limit = NUM * FAIR_PACKETS;
    mask       = below_mask(FAIR_PACKETS);
    while (mask != '0) begin
      run_cycle(mask, 1'b0);
      mask = below_mask(FAIR_PACKETS);
    end
    rr_check = 1'b1;
    rr_next  = 0;
    drain_outputs();
    rr_check = 1'b0;

    // Random pushes at one half, pops at three quarters
    test_name  = "random traffic";
    push_limit = pushed_total + RANDOM_PACKETS;
    while (pushed_total < push_limit) begin
      for (int i = 0; i < NUM; i++) begin
        mask[i] = (($random(seed) & 1) != 0);
      end
      run_cycle(mask, (($random(seed) & 3) != 0));
    end
    drain_outputs();

    // Pops stopped, engines push whenever ready
    test_name     = "back-pressure";
    push_limit    = pushed_total + 2 * HOLD_MAX;
    saw_prog_full = 1'b0;
    while (!saw_prog_full || request_ready != '0) begin
      run_cycle('1, 1'b0);
      if (request_out_prog_full) begin
        saw_prog_full = 1'b1;
      end
    end
    repeat (20) run_cycle('1, 1'b0);
    compare("request_ready while backed up", '0, CHK_W'(request_ready));
    compare("request_out_prog_full while backed up", CHK_W'(1'b1),
            CHK_W'(request_out_prog_full));
    drain_outputs();

    // Idle tail, a valid here would have no pop behind it
    repeat (10) run_cycle('0, 1'b0);
    $display("sim passed");
    $finish;
  end

endmodule

// File: hw/request_merge_engine.sv
// Engines may send only when their ready was high the cycle before and the consumer pops only when not empty
`include "request_defs.svh"

module request_merge_engine #(
  parameter int NUM_ENGINES = `REQ_NUM_ENGINES
) (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  logic [NUM_ENGINES-1:0]       request_in_valid,
  input  request_pkg::engine_payload_t request_in_payload [NUM_ENGINES],
  output logic [NUM_ENGINES-1:0]       request_ready,
  input  logic                         request_pop,
  output logic                         request_out_valid,
  output request_pkg::engine_payload_t request_out_payload,
  output logic                         request_out_empty,
  output logic                         request_out_prog_full,
  output logic                         fifo_setup
);

  localparam int PAYLOAD_W = $bits(request_pkg::engine_payload_t);

  // ----------------------------------------------------------------------
  // Signals
  // ----------------------------------------------------------------------
  // Registered reset copies
  logic areset_fifo;
  logic areset_arbiter;

  // Input registers
  logic [NUM_ENGINES-1:0]       in_valid_q;
  request_pkg::engine_payload_t in_payload_q [NUM_ENGINES];

  // Input FIFO read side and flags
  request_pkg::engine_payload_t in_fifo_dout [NUM_ENGINES];
  logic [NUM_ENGINES-1:0]       in_fifo_valid;
  logic [NUM_ENGINES-1:0]       in_fifo_empty;
  logic [NUM_ENGINES-1:0]       in_fifo_full;
  logic [NUM_ENGINES-1:0]       in_fifo_prog_full;
  logic [NUM_ENGINES-1:0]       in_fifo_busy;

  // Arbiter
  logic [NUM_ENGINES-1:0]       arb_grant;
  logic                         arb_out_valid;
  request_pkg::engine_payload_t arb_out;

  // Output FIFO write register
  logic                         out_wr_valid_q;
  request_pkg::engine_payload_t out_wr_data_q;

  // Output FIFO read side and flags
  logic                         out_rd_en;
  request_pkg::engine_payload_t out_fifo_dout;
  logic                         out_fifo_valid;
  logic                         out_fifo_empty;
  logic                         out_fifo_full;
  logic                         out_fifo_prog_full;
  logic                         out_fifo_busy;

  // Any FIFO still in its busy window
  logic                         setup_int;

  // ----------------------------------------------------------------------
  // Reset distribution
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    areset_fifo    <= areset_control;
    areset_arbiter <= areset_control;
  end

  // ----------------------------------------------------------------------
  // Engine input registers
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_q <= '0;
    end else begin
      in_valid_q <= request_in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_ENGINES; i++) begin
      in_payload_q[i] <= request_in_payload[i];
    end
  end

  // ----------------------------------------------------------------------
  // Per-engine input FIFOs
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_in_fifo
    // Read strobe comes straight from the grant
    request_sync_fifo #(
      .DEPTH      (`REQ_IN_DEPTH),
      .WIDTH      (PAYLOAD_W),
      .PROG_THRESH(`REQ_IN_THRESH)
    ) u_in_fifo (
      .ap_clk    (ap_clk),
      .reset     (areset_fifo),
      .din       (in_payload_q[i]),
      .wr_en     (in_valid_q[i]),
      .rd_en     (arb_grant[i]),
      .dout      (in_fifo_dout[i]),
      .out_valid (in_fifo_valid[i]),
      .empty     (in_fifo_empty[i]),
      .full      (in_fifo_full[i]),
      .prog_full (in_fifo_prog_full[i]),
      .reset_busy(in_fifo_busy[i])
    );

    // Engine keeps to the ready rule
    a_valid_after_ready: assert property (@(posedge ap_clk) disable iff (areset_control)
      request_in_valid[i] |-> $past(request_ready[i]))
      else $error("engine sent while not ready");

    // Threshold leaves enough room for the ready latency
    a_in_never_full: assert property (@(posedge ap_clk) disable iff (areset_control)
      !in_fifo_full[i])
      else $error("input FIFO reached full");
  end

  // ----------------------------------------------------------------------
  // Round-robin arbiter
  // ----------------------------------------------------------------------
  // Hold while the output FIFO is past its threshold
  request_rr_arbiter #(
    .NUM_REQ(NUM_ENGINES)
  ) u_arbiter (
    .ap_clk       (ap_clk),
    .reset        (areset_arbiter),
    .req          (~in_fifo_empty),
    .hold         (out_fifo_prog_full),
    .bus_in_valid (in_fifo_valid),
    .bus_in       (in_fifo_dout),
    .grant        (arb_grant),
    .bus_out_valid(arb_out_valid),
    .bus_out      (arb_out)
  );

  // Write register in front of the output FIFO
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_wr_valid_q <= 1'b0;
    end else begin
      out_wr_valid_q <= arb_out_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_wr_data_q <= arb_out;
  end

  // ----------------------------------------------------------------------
  // Output FIFO
  // ----------------------------------------------------------------------
  assign out_rd_en = request_pop & ~out_fifo_empty;

  request_sync_fifo #(
    .DEPTH      (`REQ_OUT_DEPTH),
    .WIDTH      (PAYLOAD_W),
    .PROG_THRESH(`REQ_OUT_THRESH)
  ) u_out_fifo (
    .ap_clk    (ap_clk),
    .reset     (areset_fifo),
    .din       (out_wr_data_q),
    .wr_en     (out_wr_valid_q),
    .rd_en     (out_rd_en),
    .dout      (out_fifo_dout),
    .out_valid (out_fifo_valid),
    .empty     (out_fifo_empty),
    .full      (out_fifo_full),
    .prog_full (out_fifo_prog_full),
    .reset_busy(out_fifo_busy)
  );

  // Hold stops grants early enough for words in flight
  a_out_never_full: assert property (@(posedge ap_clk) disable iff (areset_control)
    !out_fifo_full)
    else $error("output FIFO reached full");

  // Consumer sees the FIFO's own registered flag
  assign request_out_empty = out_fifo_empty;

  // ----------------------------------------------------------------------
  // Output register, ready and setup
  // ----------------------------------------------------------------------
  assign setup_int = out_fifo_busy | (|in_fifo_busy);

  // Pop to valid is two cycles
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_out_valid <= 1'b0;
    end else begin
      request_out_valid <= out_fifo_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    request_out_payload <= out_fifo_dout;
  end

  // Ready stays low until setup is done
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_setup            <= 1'b1;
      request_out_prog_full <= 1'b0;
      request_ready         <= '0;
    end else begin
      fifo_setup            <= setup_int;
      request_out_prog_full <= out_fifo_prog_full;
      request_ready         <= ~in_fifo_prog_full &
                               {NUM_ENGINES{~out_fifo_prog_full & ~setup_int}};
    end
  end

endmodule

// File: hw/request_rr_arbiter.sv
// Requestors must return read data exactly one cycle after their grant with at most one word in flight each
module request_rr_arbiter #(
  parameter int NUM_REQ = 4
) (
  input  logic                         ap_clk,
  input  logic                         reset,
  input  logic [NUM_REQ-1:0]           req,
  input  logic                         hold,
  input  logic [NUM_REQ-1:0]           bus_in_valid,
  input  request_pkg::engine_payload_t bus_in [NUM_REQ],
  output logic [NUM_REQ-1:0]           grant,
  output logic                         bus_out_valid,
  output request_pkg::engine_payload_t bus_out
);

  localparam int PTR_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  // Index of the last winner
  logic [PTR_W-1:0]             last_ptr;
  // Granted last cycle and data still on its way
  logic [NUM_REQ-1:0]           pending;
  logic [NUM_REQ-1:0]           eligible;
  logic                         grant_found;
  logic [PTR_W-1:0]             grant_idx;
  // Word picked from the bus inputs
  request_pkg::engine_payload_t bus_sel;

  // ----------------------------------------------------------------------
  // Request selection
  // ----------------------------------------------------------------------
  assign eligible = req & ~pending;

  // Search starts one past the last winner
  always_comb begin
    int idx;
    idx         = 0;
    grant_found = 1'b0;
    grant_idx   = last_ptr;
    for (int k = 1; k <= NUM_REQ; k++) begin
      idx = (int'(last_ptr) + k) % NUM_REQ;
      if (!grant_found && eligible[idx]) begin
        grant_found = 1'b1;
        grant_idx   = PTR_W'(idx);
      end
    end
  end

  // Grant goes out in the same cycle
  always_comb begin
    grant = '0;
    if (grant_found && !hold) begin
      grant[grant_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Priority pointer and in-flight mask
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      // Engine 0 wins first
      last_ptr <= PTR_W'(NUM_REQ - 1);
      pending  <= '0;
    end else begin
      if (|grant) begin
        last_ptr <= grant_idx;
      end
      pending <= grant;
    end
  end

  // ----------------------------------------------------------------------
  // Bus output register
  // ----------------------------------------------------------------------
  // Only one valid input per cycle
  always_comb begin
    bus_sel = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (bus_in_valid[i]) begin
        bus_sel = bus_in[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      bus_out_valid <= 1'b0;
    end else begin
      bus_out_valid <= |bus_in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    bus_out <= bus_sel;
  end

  // ----------------------------------------------------------------------
  // Protocol checks
  // ----------------------------------------------------------------------
  // FIFOs answer only the single granted read
  a_bus_in_single: assert property (@(posedge ap_clk) disable iff (reset)
    $onehot0(bus_in_valid))
    else $error("several bus inputs valid together");

  // Each grant returns data from the same requestor next cycle
  a_grant_returns: assert property (@(posedge ap_clk) disable iff (reset)
    (|grant) |=> (bus_in_valid == $past(grant)))
    else $error("granted requestor did not return data");

endmodule

// File: hw/request_sync_fifo.sv
// PROG_THRESH must not exceed DEPTH and reads on empty or writes on full are dropped
`include "request_defs.svh"

module request_sync_fifo #(
  parameter int DEPTH       = 16,
  parameter int WIDTH       = 68,
  parameter int PROG_THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             out_valid,
  output logic             empty,
  output logic             full,
  output logic             prog_full,
  output logic             reset_busy
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int BUSY_W = $clog2(`REQ_RST_BUSY_CYCLES + 2);

  // Storage array
  logic [WIDTH-1:0]  mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  // Occupancy now and after this edge
  logic [CNT_W-1:0]  count;
  logic [CNT_W-1:0]  count_next;
  logic              do_wr;
  logic              do_rd;
  // Cycles left in the busy window
  logic [BUSY_W-1:0] busy_cnt;

  // ----------------------------------------------------------------------
  // Qualified strobes
  // ----------------------------------------------------------------------
  // Flags are registered so they already match count
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  // Occupancy after this edge
  always_comb begin
    count_next = count;
    if (do_wr && !do_rd) begin
      count_next = count + 1'b1;
    end else if (do_rd && !do_wr) begin
      count_next = count - 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers, count and flags
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      empty     <= 1'b1;
      full      <= 1'b0;
      prog_full <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      // Wrap at DEPTH so odd depths work too
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count_next;
      empty     <= (count_next == '0);
      full      <= (count_next == CNT_W'(DEPTH));
      // Threshold compare on the new occupancy
      prog_full <= (count_next >= CNT_W'(PROG_THRESH));
      // Read data shows up one cycle after the strobe
      out_valid <= do_rd;
    end
  end

  // ----------------------------------------------------------------------
  // Storage and registered read port
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

  // ----------------------------------------------------------------------
  // Reset-busy window
  // ----------------------------------------------------------------------
  // High in reset, then for REQ_RST_BUSY_CYCLES more cycles
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      busy_cnt   <= BUSY_W'(`REQ_RST_BUSY_CYCLES);
      reset_busy <= 1'b1;
    end else begin
      reset_busy <= (busy_cnt > BUSY_W'(1));
      if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks on the surrounding logic
  // ----------------------------------------------------------------------
  // Reader must watch empty
  a_no_read_empty: assert property (@(posedge ap_clk) disable iff (reset)
    !(rd_en && empty))
    else $error("read strobe on empty FIFO");

  // Writer must watch prog_full early enough
  a_no_write_full: assert property (@(posedge ap_clk) disable iff (reset)
    !(wr_en && full))
    else $error("write strobe on full FIFO");

endmodule

// File: hw/request_pkg.sv
// Field widths come from request_defs.svh and engine_id is set by the sending engine
`include "request_defs.svh"

package request_pkg;

  // ----------------------------------------------------------------------
  // Request packet carried from the engines to the memory side
  // ----------------------------------------------------------------------
  typedef struct packed {
    // Source engine index
    logic [`REQ_ENGINE_ID_W-1:0] engine_id;
    // Target vertex
    logic [`REQ_VERTEX_W-1:0] vertex_id;
    // Request data word
    logic [`REQ_DATA_W-1:0] data;
  } engine_payload_t;

  // 68 bits with the default widths

endpackage

// File: hw/request_defs.svh
// Sizes shared by RTL and testbench and the thresholds assume one cycle of ready latency per stage
`ifndef REQUEST_DEFS_SVH
`define REQUEST_DEFS_SVH

// ----------------------------------------------------------------------
// Engine count and payload field widths
// ----------------------------------------------------------------------
// Default number of request engines
`define REQ_NUM_ENGINES 4
// Engine id field has to hold every engine index
`define REQ_ENGINE_ID_W 4
`define REQ_VERTEX_W 32
`define REQ_DATA_W 32

// ----------------------------------------------------------------------
// FIFO sizing
// ----------------------------------------------------------------------
// Per-engine input FIFO
`define REQ_IN_DEPTH 16
// Headroom of four words for packets still in flight
`define REQ_IN_THRESH 12
// Shared output FIFO
`define REQ_OUT_DEPTH 32
`define REQ_OUT_THRESH 19
// Busy window after a FIFO leaves reset
`define REQ_RST_BUSY_CYCLES 2

`endif
